// ==== verilog/sram_fb_pkg.sv ====
package sram_fb_pkg;

    // ########################################################################
    // SRAM geometry
    // ########################################################################

    localparam int SRAM_AW = 20;  // Word address, 1M words
    localparam int SRAM_DW = 16;

    typedef logic [SRAM_AW-1:0] sram_addr_t;
    typedef logic [SRAM_DW-1:0] pixel_t;

    // ########################################################################
    // FIFO payloads and arbiter states
    // ########################################################################

    // One beat of the read stream, sof marks pixel 0 of a pass
    typedef struct packed {
        logic   sof;
        pixel_t pixel;
    } rd_beat_t;

    typedef enum logic [1:0] {
        IDLE,          // Choosing the next access
        REQ,           // Request raised, waiting for ack
        WAIT_ACK_LOW,  // Request dropped, waiting for the engine to let go of ack
        DONE           // One spare cycle before the next request
    } arb_state_e;

endpackage

// ==== verilog/sram_cmd_if.sv ====
interface sram_cmd_if;
    import sram_fb_pkg::*;

    logic       req;
    logic       we;     // High for a write, low for a read
    sram_addr_t addr;
    pixel_t     wdata;
    logic       ack;
    pixel_t     rdata;  // Valid while ack is high on a read

    // Four-phase handshake, req and the command stay put until ack is seen
    modport arbiter (
        output req,
        output we,
        output addr,
        output wdata,
        input  ack,
        input  rdata
    );

    modport engine (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output ack,
        output rdata
    );

endinterface

// ==== verilog/sync_fifo.sv ====
module sync_fifo #(
    parameter type payload_t  = logic [15:0],
    parameter int  FIFO_DEPTH = 8
) (
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  logic                            i_push,
    input  payload_t                        i_data,
    input  logic                            i_pop,
    output payload_t                        o_data,
    output logic                            o_full,
    output logic                            o_empty,
    output logic [$clog2(FIFO_DEPTH+1)-1:0] o_count
);

    localparam int PW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    payload_t      mem [FIFO_DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [CW-1:0] count_q;
    logic [CW-1:0] count_d;
    logic          do_push;
    logic          do_pop;

    // Pointers wrap at the depth, which need not be a power of two
    function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] ptr);
        return (ptr == PW'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign do_push = i_push && !o_full;   // A push into a full FIFO is lost
    assign do_pop  = i_pop && !o_empty;
    assign count_d = count_q + CW'(do_push) - CW'(do_pop);

    assign o_data  = mem[rd_ptr];
    assign o_count = count_q;

    always_ff @(posedge i_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count_q <= '0;
            o_full  <= 1'b0;
            o_empty <= 1'b1;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count_q <= count_d;
            o_full  <= (count_d == CW'(FIFO_DEPTH));
            o_empty <= (count_d == '0);
        end
    end

endmodule

// ==== verilog/frame_addr_counter.sv ====
module frame_addr_counter #(
    parameter int FRAME_PIXELS = 480000
) (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_wr_done,
    input  logic                   i_rd_done,
    output sram_fb_pkg::sram_addr_t o_wr_addr,
    output sram_fb_pkg::sram_addr_t o_rd_addr,
    output logic                   o_rd_sof,
    output logic                   o_frame_valid,
    output logic                   o_frame_done
);
    import sram_fb_pkg::*;

    localparam sram_addr_t LAST_PIXEL = sram_addr_t'(FRAME_PIXELS - 1);
    localparam sram_addr_t BANK1_BASE = sram_addr_t'(FRAME_PIXELS);

    sram_addr_t wr_cnt;
    sram_addr_t rd_cnt;
    logic       wr_bank;    // Bank being filled
    logic       done_bank;  // Newest complete bank
    logic       rd_bank;    // Bank of the current read pass
    logic       wr_wrap;

    assign wr_wrap = i_wr_done && (wr_cnt == LAST_PIXEL);

    assign o_wr_addr = (wr_bank ? BANK1_BASE : '0) + wr_cnt;
    assign o_rd_addr = (rd_bank ? BANK1_BASE : '0) + rd_cnt;
    assign o_rd_sof  = (rd_cnt == '0);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_cnt        <= '0;
            wr_bank       <= 1'b0;
            done_bank     <= 1'b0;
            o_frame_valid <= 1'b0;
            o_frame_done  <= 1'b0;
        end else begin
            o_frame_done <= wr_wrap;
            if (wr_wrap) begin
                wr_cnt        <= '0;
                wr_bank       <= ~wr_bank;
                done_bank     <= wr_bank;
                o_frame_valid <= 1'b1;
            end else if (i_wr_done) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
        end
    end

    // The arbiter never reports a write and a read in the same cycle
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rd_cnt  <= '0;
            rd_bank <= 1'b0;
        end else if (i_rd_done) begin
            if (rd_cnt == LAST_PIXEL) begin
                rd_cnt  <= '0;
                rd_bank <= done_bank;
            end else begin
                rd_cnt <= rd_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== verilog/sram_arbiter_fsm.sv ====
module sram_arbiter_fsm #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  logic                            i_wr_empty,
    output logic                            o_wr_pop,
    input  sram_fb_pkg::pixel_t             i_wr_pixel,
    input  logic [$clog2(FIFO_DEPTH+1)-1:0] i_rd_count,
    output logic                            o_rd_push,
    output sram_fb_pkg::rd_beat_t           o_rd_beat,
    input  sram_fb_pkg::sram_addr_t         i_wr_addr,
    input  sram_fb_pkg::sram_addr_t         i_rd_addr,
    input  logic                            i_rd_sof,
    input  logic                            i_frame_valid,
    output logic                            o_wr_done,
    output logic                            o_rd_done,
    sram_cmd_if.arbiter                     cmd
);
    import sram_fb_pkg::*;

    localparam int CW = $clog2(FIFO_DEPTH + 1);

    arb_state_e state_q;
    logic       rr_q;      // Last access was a write, so a waiting read goes first
    logic       sof_q;
    logic       wr_ok;
    logic       rd_ok;
    logic       issue;
    logic       issue_wr;
    logic       ack_seen;

    // ########################################################################
    // Access selection
    // ########################################################################

    // Only one access is ever outstanding and its beat is counted before IDLE
    assign wr_ok    = !i_wr_empty;
    assign rd_ok    = i_frame_valid && (i_rd_count < CW'(FIFO_DEPTH));
    assign issue_wr = wr_ok && (!rd_ok || !rr_q);
    assign issue    = (state_q == IDLE) && (wr_ok || rd_ok);
    assign ack_seen = (state_q == REQ) && cmd.ack;

    assign o_wr_pop  = issue && issue_wr;     // Pixel leaves the FIFO as it is latched
    assign o_wr_done = ack_seen && cmd.we;
    assign o_rd_done = ack_seen && !cmd.we;
    assign o_rd_push = o_rd_done;
    assign o_rd_beat = '{sof: sof_q, pixel: cmd.rdata};

    // ########################################################################
    // Handshake state machine
    // ########################################################################

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= IDLE;
            cmd.req <= 1'b0;
            cmd.we  <= 1'b0;
            rr_q    <= 1'b0;
            sof_q   <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (issue) begin
                        cmd.req <= 1'b1;
                        cmd.we  <= issue_wr;
                        sof_q   <= !issue_wr && i_rd_sof;
                        state_q <= REQ;
                    end
                end
                REQ: begin
                    if (cmd.ack) begin
                        cmd.req <= 1'b0;
                        state_q <= WAIT_ACK_LOW;
                    end
                end
                WAIT_ACK_LOW: begin
                    if (!cmd.ack) begin
                        state_q <= DONE;
                    end
                end
                DONE: begin
                    rr_q    <= cmd.we;
                    state_q <= IDLE;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    // Command payload, held until the access is acknowledged
    always_ff @(posedge i_clk) begin
        if (issue) begin
            cmd.addr  <= issue_wr ? i_wr_addr : i_rd_addr;
            cmd.wdata <= i_wr_pixel;
        end
    end

endmodule

// ==== verilog/sram_phy.sv ====
module sram_phy (
    input  logic                                i_clk,
    input  logic                                i_rst_n,
    sram_cmd_if.engine                          cmd,
    output sram_fb_pkg::sram_addr_t             o_sram_addr,
    inout  wire [sram_fb_pkg::SRAM_DW-1:0]      io_sram_dq,
    output logic                                o_sram_we_n,
    output logic                                o_sram_ce_n,
    output logic                                o_sram_oe_n
);
    import sram_fb_pkg::*;

    logic [1:0] cyc_q;    // 0 idle, 1 setup, 2 strobe, 3 holding ack
    logic       wr_q;
    logic       dq_oe_q;
    sram_addr_t addr_q;
    pixel_t     wdata_q;

    assign o_sram_addr = addr_q;
    assign io_sram_dq  = dq_oe_q ? wdata_q : {SRAM_DW{1'bz}};

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cyc_q       <= 2'd0;
            wr_q        <= 1'b0;
            dq_oe_q     <= 1'b0;
            o_sram_ce_n <= 1'b1;
            o_sram_we_n <= 1'b1;
            o_sram_oe_n <= 1'b1;
            cmd.ack     <= 1'b0;
        end else begin
            case (cyc_q)
                2'd0: begin
                    if (cmd.req) begin
                        cyc_q       <= 2'd1;
                        wr_q        <= cmd.we;
                        dq_oe_q     <= cmd.we;
                        o_sram_ce_n <= 1'b0;
                        o_sram_oe_n <= cmd.we;  // Output enable only on reads
                    end
                end
                2'd1: begin
                    cyc_q       <= 2'd2;
                    o_sram_we_n <= !wr_q;
                end
                2'd2: begin
                    cyc_q       <= 2'd3;
                    o_sram_ce_n <= 1'b1;
                    o_sram_we_n <= 1'b1;
                    o_sram_oe_n <= 1'b1;
                    dq_oe_q     <= 1'b0;
                    cmd.ack     <= 1'b1;
                end
                default: begin
                    if (!cmd.req) begin
                        cmd.ack <= 1'b0;
                        cyc_q   <= 2'd0;
                    end
                end
            endcase
        end
    end

    // Address and write data are taken at the start, read data at the end of the strobe
    always_ff @(posedge i_clk) begin
        if (cyc_q == 2'd0 && cmd.req) begin
            addr_q  <= cmd.addr;
            wdata_q <= cmd.wdata;
        end
        if (cyc_q == 2'd2 && !wr_q) begin
            cmd.rdata <= io_sram_dq;
        end
    end

endmodule

// ==== verilog/sram_frame_buffer.sv ====
module sram_frame_buffer #(
    parameter int FRAME_PIXELS = 480000,
    parameter int FIFO_DEPTH   = 8
) (
    input  logic                              i_clk,
    input  logic                              i_rst_n,

    input  sram_fb_pkg::pixel_t               i_wr_data,
    input  logic                              i_wr_valid,
    output logic                              o_wr_full,
    output logic                              o_finish,

    input  logic                              i_rd_request,
    output logic                              o_rd_valid,
    output sram_fb_pkg::pixel_t               o_rd_data,
    output logic                              o_rd_sof,

    output sram_fb_pkg::sram_addr_t           o_sram_addr,
    inout  wire [sram_fb_pkg::SRAM_DW-1:0]    io_sram_dq,
    output logic                              o_sram_we_n,
    output logic                              o_sram_ce_n,
    output logic                              o_sram_oe_n
);
    import sram_fb_pkg::*;

    localparam int CW = $clog2(FIFO_DEPTH + 1);

    pixel_t        wr_pixel;
    logic          wr_empty;
    logic          wr_pop;
    rd_beat_t      rd_push_beat;
    rd_beat_t      rd_beat;
    logic          rd_push;
    logic          rd_empty;
    logic [CW-1:0] rd_count;
    sram_addr_t    wr_addr;
    sram_addr_t    rd_addr;
    logic          rd_sof;
    logic          frame_valid;
    logic          wr_done;
    logic          rd_done;

    sram_cmd_if cmd_if ();

    assign o_rd_valid = ~rd_empty;
    assign o_rd_data  = rd_beat.pixel;
    assign o_rd_sof   = rd_beat.sof;

    // ########################################################################
    // Pixel FIFOs
    // ########################################################################

    sync_fifo #(
        .payload_t (pixel_t),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) wr_fifo_inst (
        .i_clk  (i_clk),
        .i_rst_n(i_rst_n),
        .i_push (i_wr_valid),
        .i_data (i_wr_data),
        .i_pop  (wr_pop),
        .o_data (wr_pixel),
        .o_full (o_wr_full),
        .o_empty(wr_empty),
        .o_count()
    );

    sync_fifo #(
        .payload_t (rd_beat_t),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) rd_fifo_inst (
        .i_clk  (i_clk),
        .i_rst_n(i_rst_n),
        .i_push (rd_push),
        .i_data (rd_push_beat),
        .i_pop  (i_rd_request),
        .o_data (rd_beat),
        .o_full (),
        .o_empty(rd_empty),
        .o_count(rd_count)
    );

    // ########################################################################
    // Addressing, arbitration and the SRAM cycle engine
    // ########################################################################

    frame_addr_counter #(
        .FRAME_PIXELS(FRAME_PIXELS)
    ) frame_addr_counter_inst (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_wr_done    (wr_done),
        .i_rd_done    (rd_done),
        .o_wr_addr    (wr_addr),
        .o_rd_addr    (rd_addr),
        .o_rd_sof     (rd_sof),
        .o_frame_valid(frame_valid),
        .o_frame_done (o_finish)
    );

    sram_arbiter_fsm #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) sram_arbiter_fsm_inst (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_wr_empty   (wr_empty),
        .o_wr_pop     (wr_pop),
        .i_wr_pixel   (wr_pixel),
        .i_rd_count   (rd_count),
        .o_rd_push    (rd_push),
        .o_rd_beat    (rd_push_beat),
        .i_wr_addr    (wr_addr),
        .i_rd_addr    (rd_addr),
        .i_rd_sof     (rd_sof),
        .i_frame_valid(frame_valid),
        .o_wr_done    (wr_done),
        .o_rd_done    (rd_done),
        .cmd          (cmd_if.arbiter)
    );

    sram_phy sram_phy_inst (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .cmd        (cmd_if.engine),
        .o_sram_addr(o_sram_addr),
        .io_sram_dq (io_sram_dq),
        .o_sram_we_n(o_sram_we_n),
        .o_sram_ce_n(o_sram_ce_n),
        .o_sram_oe_n(o_sram_oe_n)
    );

endmodule

// ==== dv/sram_model.sv ====
module sram_model (
    input  sram_fb_pkg::sram_addr_t         i_addr,
    inout  wire [sram_fb_pkg::SRAM_DW-1:0]  io_dq,
    input  logic                            i_we_n,
    input  logic                            i_ce_n,
    input  logic                            i_oe_n
);
    import sram_fb_pkg::*;

    pixel_t mem [sram_addr_t];  // Only written words take up space

    function automatic pixel_t read_word(input sram_addr_t addr);
        return mem.exists(addr) ? mem[addr] : 16'hdead;
    endfunction

    assign io_dq = (!i_ce_n && !i_oe_n && i_we_n) ? read_word(i_addr) : {SRAM_DW{1'bz}};

    // DQ and the address are already stable when WE_N falls
    always @(negedge i_we_n) begin
        if (!i_ce_n) begin
            mem[i_addr] = io_dq;
        end
    end

endmodule

// ==== dv/sram_checker.sv ====
module sram_checker (
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  logic                            i_req,
    input  logic                            i_ack,
    input  logic                            i_we_n,
    input  logic                            i_ce_n,
    input  sram_fb_pkg::sram_addr_t         i_addr,
    input  logic [sram_fb_pkg::SRAM_DW-1:0] i_dq
);

    int fail_cnt = 0;

    // Four-phase handshake
    req_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_req && !i_ack) |=> i_req)
        else begin
            fail_cnt++;
            $error("req dropped before ack");
        end

    ack_rise: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $rose(i_ack) |-> i_req)
        else begin
            fail_cnt++;
            $error("ack rose without req");
        end

    // ########################################################################
    // SRAM pins
    // ########################################################################

    dq_driven: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !i_we_n |-> !$isunknown(i_dq))
        else begin
            fail_cnt++;
            $error("DQ floating during a write strobe");
        end

    addr_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (!i_ce_n && $past(!i_ce_n)) |-> $stable(i_addr))
        else begin
            fail_cnt++;
            $error("address moved while CE_N was low");
        end

endmodule

// ==== dv/tb_scoreboard.sv ====
module tb_scoreboard #(
    parameter int FRAME_PIXELS = 16
) (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_wr_valid,
    input  logic                i_wr_full,
    input  sram_fb_pkg::pixel_t i_wr_data,
    input  logic                i_finish,
    input  logic                i_rd_valid,
    input  logic                i_rd_request,
    input  sram_fb_pkg::pixel_t i_rd_data,
    input  logic                i_rd_sof
);
    import sram_fb_pkg::*;

    pixel_t sent_q [$];      // Every accepted pixel, in write order
    int     frames_done = 0;
    int     cur_frame   = 0; // Frame of the pass being read
    int     idx         = 0;
    int     in_pass     = 0;
    int     passes_done = 0;
    int     errors      = 0;

    // Pixel idx of completed frame number frame, as it was written
    function automatic pixel_t expected_pixel(input int frame, input int index);
        return sent_q[frame * FRAME_PIXELS + index];
    endfunction

    always @(posedge i_clk) begin
        int found;
        found = -1;
        if (i_rst_n) begin
            if (i_wr_valid && !i_wr_full) sent_q.push_back(i_wr_data);
            if (i_finish) begin
                if (sent_q.size() < (frames_done + 1) * FRAME_PIXELS) begin
                    errors++;
                    $display("%0t: o_finish pulsed before a whole frame was written", $time);
                end
                frames_done++;
            end
            if (i_rd_valid && frames_done == 0) begin
                errors++;
                $display("%0t: read data appeared before the first frame was done", $time);
            end
            if (i_rd_valid && i_rd_request && frames_done > 0) begin
                if (i_rd_sof) begin
                    if (in_pass && idx != FRAME_PIXELS) begin
                        errors++;
                        $display("%0t: pass cut short after %0d pixels", $time, idx);
                    end
                    // Newest frame first, never one older than the last pass
                    for (int f = frames_done - 1; f >= cur_frame && found < 0; f--) begin
                        if (expected_pixel(f, 0) == i_rd_data) found = f;
                    end
                    if (found < 0) begin
                        errors++;
                        $display("[ERROR] %0t o_rd_data expected frame %0d pixel 0 %h got %h",
                                 $time, cur_frame, expected_pixel(cur_frame, 0), i_rd_data);
                    end else begin
                        cur_frame = found;
                    end
                    in_pass = 1;
                    idx     = 1;
                end else if (!in_pass || idx >= FRAME_PIXELS) begin
                    errors++;
                    $display("%0t: read pixel without a start of frame", $time);
                end else begin
                    if (i_rd_data !== expected_pixel(cur_frame, idx)) begin
                        errors++;
                        $display("[ERROR] %0t o_rd_data expected %h got %h", $time,
                                 expected_pixel(cur_frame, idx), i_rd_data);
                    end
                    idx++;
                end
                if (in_pass && idx == FRAME_PIXELS) passes_done++;
            end
        end
    end

endmodule

// ==== dv/tb_top.sv ====
module tb_top;
    import sram_fb_pkg::*;

    localparam int FRAME_PIXELS = 16;
    localparam int FIFO_DEPTH   = 4;
    localparam int NUM_TESTS    = 6;
    localparam int NUM_FRAMES   = 3;
    localparam int TIME_LIMIT   = (NUM_TESTS * NUM_FRAMES * FRAME_PIXELS * 20 + 2000) * 100;

    logic       i_clk = 1'b0;
    logic       i_rst_n;
    pixel_t     i_wr_data;
    logic       i_wr_valid;
    logic       i_rd_request;
    logic       o_wr_full;
    logic       o_finish;
    logic       o_rd_valid;
    logic       o_rd_sof;
    pixel_t     o_rd_data;
    sram_addr_t sram_addr;
    wire [SRAM_DW-1:0] sram_dq;
    logic       sram_we_n;
    logic       sram_ce_n;
    logic       sram_oe_n;
    int         seed = 32'hd2088281;
    int         tests_failed = 0;
    int         saw_full = 0;

    sram_frame_buffer #(
        .FRAME_PIXELS(FRAME_PIXELS),
        .FIFO_DEPTH  (FIFO_DEPTH)
    ) sram_frame_buffer_inst (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_wr_data(i_wr_data), .i_wr_valid(i_wr_valid),
        .o_wr_full(o_wr_full), .o_finish(o_finish), .i_rd_request(i_rd_request),
        .o_rd_valid(o_rd_valid), .o_rd_data(o_rd_data), .o_rd_sof(o_rd_sof),
        .o_sram_addr(sram_addr), .io_sram_dq(sram_dq), .o_sram_we_n(sram_we_n),
        .o_sram_ce_n(sram_ce_n), .o_sram_oe_n(sram_oe_n)
    );

    sram_model sram_model_inst (.i_addr(sram_addr), .io_dq(sram_dq), .i_we_n(sram_we_n),
                                .i_ce_n(sram_ce_n), .i_oe_n(sram_oe_n));

    tb_scoreboard #(.FRAME_PIXELS(FRAME_PIXELS)) sb_inst (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_wr_valid(i_wr_valid), .i_wr_full(o_wr_full),
        .i_wr_data(i_wr_data), .i_finish(o_finish), .i_rd_valid(o_rd_valid),
        .i_rd_request(i_rd_request), .i_rd_data(o_rd_data), .i_rd_sof(o_rd_sof)
    );

    bind sram_phy sram_checker sram_checker_inst (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_req(cmd.req), .i_ack(cmd.ack),
        .i_we_n(o_sram_we_n), .i_ce_n(o_sram_ce_n), .i_addr(o_sram_addr), .i_dq(io_sram_dq)
    );

    initial begin
        forever #50 i_clk = ~i_clk;
    end

    initial begin
        #(TIME_LIMIT);
        $display("Timeout: the tests did not finish in %0d time units", TIME_LIMIT);
        $display("SOME TESTS FAILED");
        $finish;
    end

    // ########################################################################
    // Stimulus tasks
    // ########################################################################

    // Junk pushed into a full FIFO must never come back out
    task automatic send_pixels(input int n, input bit hammer);
        int sent;
        sent = 0;
        while (sent < n) begin
            @(negedge i_clk);
            i_wr_valid = 1'b0;
            if (!o_wr_full) begin
                i_wr_valid = 1'b1;
                i_wr_data  = pixel_t'($random(seed));
                sent++;
            end else begin
                saw_full = 1;
                if (hammer) begin
                    i_wr_valid = 1'b1;
                    i_wr_data  = pixel_t'($random(seed));
                end
            end
        end
        @(negedge i_clk);
        i_wr_valid = 1'b0;
    endtask

    task automatic expect_bit(input string name, input logic got, input logic exp, inout bit ok);
        if (got !== exp) begin
            $display("[ERROR] %0t %s expected %b got %b", $time, name, exp, got);
            ok = 1'b0;
        end
    endtask

    task automatic finish_test(input int num, input string name, input int err0, input bit ok);
        if (ok && sb_inst.errors == err0) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAILED", num, name);
        end
    endtask

    initial begin
        int  err0;
        int  p;
        bit  ok;
        i_rst_n      = 1'b0;
        i_wr_data    = '0;
        i_wr_valid   = 1'b0;
        i_rd_request = 1'b1;
        repeat (3) @(posedge i_clk);
        @(negedge i_clk);

        // Idle levels of every output while reset is held
        ok = 1'b1;
        expect_bit("o_finish", o_finish, 1'b0, ok);
        expect_bit("o_rd_valid", o_rd_valid, 1'b0, ok);
        expect_bit("o_wr_full", o_wr_full, 1'b0, ok);
        expect_bit("o_sram_we_n", sram_we_n, 1'b1, ok);
        expect_bit("o_sram_oe_n", sram_oe_n, 1'b1, ok);
        expect_bit("o_sram_ce_n", sram_ce_n, 1'b1, ok);
        i_rst_n = 1'b1;

        err0 = sb_inst.errors;
        send_pixels(FRAME_PIXELS, 1'b0);
        wait (sb_inst.frames_done >= 1);
        repeat (20) @(posedge i_clk);
        finish_test(1, "first frame", err0, ok && sb_inst.frames_done == 1);

        err0 = sb_inst.errors;
        wait (sb_inst.passes_done >= 3);
        finish_test(2, "three passes", err0, sb_inst.frames_done == 1);

        err0 = sb_inst.errors;
        send_pixels(FRAME_PIXELS, 1'b0);
        wait (sb_inst.cur_frame == 1);
        p = sb_inst.passes_done;
        wait (sb_inst.passes_done >= p + 2);
        finish_test(3, "frame swap", err0, sb_inst.frames_done == 2);

        err0 = sb_inst.errors;
        ok   = 1'b1;
        @(negedge i_clk);
        i_rd_request = 1'b0;
        repeat (60) @(negedge i_clk);
        repeat (30) begin
            @(negedge i_clk);
            expect_bit("o_rd_valid", o_rd_valid, 1'b1, ok);
        end
        i_rd_request = 1'b1;
        p = sb_inst.passes_done;
        wait (sb_inst.passes_done >= p + 2);
        finish_test(4, "back-pressure", err0, ok);

        err0     = sb_inst.errors;
        saw_full = 0;
        send_pixels(FRAME_PIXELS, 1'b1);
        wait (sb_inst.cur_frame == 2);
        p = sb_inst.passes_done;
        wait (sb_inst.passes_done >= p + 2);
        finish_test(5, "write burst", err0, saw_full != 0 && sb_inst.frames_done == 3);

        finish_test(6, "SRAM assertions", sb_inst.errors,
                    sram_frame_buffer_inst.sram_phy_inst.sram_checker_inst.fail_cnt == 0);

        $display("%0d tests, %0d failed, %0d scoreboard errors",
                 NUM_TESTS, tests_failed, sb_inst.errors);
        if (tests_failed == 0 && sb_inst.errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+verilog
verilog/sram_fb_pkg.sv
verilog/sram_cmd_if.sv
verilog/sync_fifo.sv
verilog/frame_addr_counter.sv
verilog/sram_arbiter_fsm.sv
verilog/sram_phy.sv
verilog/sram_frame_buffer.sv
dv/sram_model.sv
dv/sram_checker.sv
dv/tb_scoreboard.sv
dv/tb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_top
FILELIST  := list.f
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing --assert
OBJ_DIR   := obj_dir
PASS_MSG  := ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The status of the pipeline is the status of grep
run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
